// File: jumpCore.f
cpuIsaPkg.sv
cpuCorePkg.sv
instructionBuffer.sv
instructionPhaseSequencer.sv
jumpGroupDecoder.sv
jumpOperandSelect.sv
programCounter.sv
jumpCore.sv
jumpCoreTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= jumpCoreTb
FILELIST ?= jumpCore.f
OBJDIR ?= obj_dir
PASS_TEXT = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJDIR)

// File: jumpCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module jumpCoreTb;

	localparam int rowCount = 27;
	localparam int creditRows = 6;
	localparam int waitLimit = 200; // cycles allowed per wait

	logic CLK;
	logic reset;
	logic instrPush;
	logic [cpuCorePkg::wordWidth-1:0] instrData;
	logic creditReturn;
	logic regWrite;
	logic [cpuCorePkg::regAddrWidth-1:0] regWriteAddr;
	logic [cpuCorePkg::wordWidth-1:0] regWriteData;
	logic ccZero;
	logic ccCarry;
	logic ccSign;
	logic ccParity;
	logic [cpuCorePkg::wordWidth-1:0] pcAddr;
	logic commit;
	logic jumpTaken;

	logic [cpuCorePkg::wordWidth-1:0] rowInstr [rowCount];
	logic [3:0] rowFlags [rowCount]; // zero, carry, sign, parity
	logic rowTaken [rowCount];
	logic [cpuCorePkg::wordWidth-1:0] creditInstr [creditRows];
	logic creditTaken [creditRows];
	logic [cpuCorePkg::wordWidth-1:0] regCopy [cpuCorePkg::regCount];
	logic [cpuCorePkg::wordWidth-1:0] modelPc;
	logic [31:0] lcgState;
	int rowFill = 0;
	int pushCount = 0;
	int returnCount = 0;
	int testCount = 0;
	int errorCount = 0;

	jumpCore uut (.CLK(CLK), .reset(reset), .instrPush(instrPush), .instrData(instrData),
		.creditReturn(creditReturn), .regWrite(regWrite), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .ccZero(ccZero), .ccCarry(ccCarry), .ccSign(ccSign),
		.ccParity(ccParity), .pcAddr(pcAddr), .commit(commit), .jumpTaken(jumpTaken));

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		if (!reset && creditReturn) returnCount++; // supplier gets a credit back
	end

	// ############################################################
	// helpers
	// ############################################################
	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [15:0] makeJump(input logic [1:0] cond, input logic [1:0] mode,
		input logic [1:0] flag, input logic [7:0] arg8);
		return {cpuIsaPkg::groupJump, cond, mode, flag, arg8};
	endfunction

	function automatic int creditsLeft();
		return cpuCorePkg::bufferDepth - pushCount + returnCount;
	endfunction

	// target from the ISA rule, pc is the already stepped value
	function automatic logic [15:0] jumpTarget(input logic [15:0] word, input logic [15:0] pc);
		logic [1:0] mode;
		logic [15:0] opB;
		mode = word[cpuIsaPkg::modeLsb +: cpuIsaPkg::modeWidth];
		if (mode == cpuIsaPkg::modeRelImm || mode == cpuIsaPkg::modeAbsImm)
			opB = {word[7:0], regCopy[cpuIsaPkg::regRB][7:0]};
		else
			opB = regCopy[word[3:0]];
		if (mode == cpuIsaPkg::modeRelReg || mode == cpuIsaPkg::modeRelImm)
			return pc + opB;
		return opB;
	endfunction

	task automatic addRow(input logic [15:0] word, input logic [3:0] flags, input logic taken);
		rowInstr[rowFill] = word;
		rowFlags[rowFill] = flags;
		rowTaken[rowFill] = taken;
		rowFill++;
	endtask

	task automatic buildTable();
		logic [31:0] rnd;
		logic [15:0] w;
		logic [3:0] flags;
		addRow(cpuIsaPkg::instrNop, 4'b0000, 1'b0);
		addRow(makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeRelReg, 2'd0, 8'h03), 4'h0, 1'b1);
		addRow(makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeAbsReg, 2'd0, 8'h05), 4'hf, 1'b1);
		addRow(makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeRelImm, 2'd1, 8'h12), 4'h0, 1'b1);
		addRow(makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeAbsImm, 2'd2, 8'h40), 4'h0, 1'b1);
		for (int f = 0; f < 4; f++) begin
			for (int v = 0; v < 2; v++) begin
				flags = v ? (4'b1000 >> f) : ~(4'b1000 >> f); // others at the opposite level
				addRow(makeJump(cpuIsaPkg::condIfSet, 2'(f), 2'(f), {4'(f), 4'(v + 6)}),
					flags, v[0]);
				addRow(makeJump(cpuIsaPkg::condIfClear, 2'(3 - f), 2'(f), {4'(v), 4'(f + 1)}),
					flags, !v[0]);
			end
		end
		addRow(makeJump(cpuIsaPkg::condNever, cpuIsaPkg::modeAbsReg, 2'd3, 8'h09), 4'hf, 1'b0);
		addRow(makeJump(cpuIsaPkg::condNever, cpuIsaPkg::modeRelImm, 2'd0, 8'h7f), 4'h0, 1'b0);
		for (int k = 0; k < 4; k++) begin
			rnd = nextRand();
			w = rnd[15:0];
			if (w[15:14] == cpuIsaPkg::groupJump) w[15:14] = 2'b11; // keep it out of the jump group
			addRow(w, rnd[19:16], 1'b0);
		end
		creditInstr[0] = cpuIsaPkg::instrNop;
		creditTaken[0] = 1'b0;
		creditInstr[1] = makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeAbsImm, 2'd0, 8'h21);
		creditTaken[1] = 1'b1;
		creditInstr[2] = makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeRelReg, 2'd0, 8'h07);
		creditTaken[2] = 1'b1;
		creditInstr[3] = 16'h4abc;
		creditTaken[3] = 1'b0;
		creditInstr[4] = makeJump(cpuIsaPkg::condNever, cpuIsaPkg::modeAbsReg, 2'd1, 8'h02);
		creditTaken[4] = 1'b0;
		creditInstr[5] = makeJump(cpuIsaPkg::condAlways, cpuIsaPkg::modeRelImm, 2'd0, 8'h01);
		creditTaken[5] = 1'b1;
	endtask

	// waits for a free credit, leaves instrPush high so pushes can run back to back
	task automatic pushInstr(input logic [15:0] word);
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (creditsLeft() == 0 && cycles < waitLimit) begin
			@(posedge CLK);
			instrPush <= 1'b0;
			@(negedge CLK);
			cycles++;
		end
		if (creditsLeft() == 0) begin
			$display("timeout waiting for a credit");
			errorCount++;
		end else begin
			@(posedge CLK);
			instrPush <= 1'b1;
			instrData <= word;
			pushCount++;
		end
	endtask

	task automatic endPush();
		@(posedge CLK);
		instrPush <= 1'b0;
	endtask

	task automatic checkCommit(input logic [15:0] word, input logic expTaken, input string label);
		int cycles;
		logic rowOk;
		cycles = 0;
		rowOk = 1'b1;
		testCount++;
		@(negedge CLK);
		while (!commit && cycles < waitLimit) begin
			@(negedge CLK);
			cycles++;
		end
		if (!commit) begin
			$display("timeout waiting for commit of %s", label);
			rowOk = 1'b0;
		end else begin
			if (jumpTaken !== expTaken) begin
				$display("Fail %0t: %s jumpTaken %b, expected %b", $time, label, jumpTaken, expTaken);
				rowOk = 1'b0;
			end
			modelPc = modelPc + cpuCorePkg::pcStep;
			if (expTaken) modelPc = jumpTarget(word, modelPc);
			@(negedge CLK); // target lands at the end of commit
			if (pcAddr !== modelPc) begin
				$display("Fail %0t: %s pcAddr %h, expected %h", $time, label, pcAddr, modelPc);
				rowOk = 1'b0;
			end
		end
		if (!rowOk) errorCount++;
		$display("%s %s", label, rowOk ? "passed" : "failed");
	endtask

	// ############################################################
	// main sequence
	// ############################################################
	initial begin
		string label;
		int cycles;
		logic resetOk;
		reset = 1'b1;
		instrPush = 1'b0;
		instrData = '0;
		regWrite = 1'b0;
		regWriteAddr = '0;
		regWriteData = '0;
		ccZero = 1'b0;
		ccCarry = 1'b0;
		ccSign = 1'b0;
		ccParity = 1'b0;
		lcgState = 32'hfb93_c80e;
		modelPc = '0;
		resetOk = 1'b1;
		repeat (16) @(posedge CLK);
		reset <= 1'b0;

		// preload registers, core must stay idle meanwhile
		for (int n = 0; n < cpuCorePkg::regCount; n++) begin
			@(posedge CLK);
			regWrite <= 1'b1;
			regWriteAddr <= 4'(n);
			regCopy[n] = 16'(nextRand() >> 8);
			regWriteData <= regCopy[n];
			@(negedge CLK);
			if (commit || jumpTaken || creditReturn || pcAddr !== 16'h0000) begin
				$display("Fail %0t: core not idle after reset", $time);
				resetOk = 1'b0;
			end
		end
		@(posedge CLK);
		regWrite <= 1'b0;
		testCount++;
		if (!resetOk) errorCount++;
		$display("reset state %s", resetOk ? "passed" : "failed");

		buildTable();
		for (int i = 0; i < rowCount; i++) begin
			@(posedge CLK);
			{ccZero, ccCarry, ccSign, ccParity} <= rowFlags[i];
			pushInstr(rowInstr[i]);
			endPush();
			label = $sformatf("row %0d (%h)", i, rowInstr[i]);
			checkCommit(rowInstr[i], rowTaken[i], label);
		end

		// two in flight, then one push per returned credit
		@(posedge CLK);
		{ccZero, ccCarry, ccSign, ccParity} <= 4'b0000;
		fork
			begin
				for (int k = 0; k < creditRows; k++) begin
					pushInstr(creditInstr[k]);
				end
				endPush();
			end
			begin
				for (int k = 0; k < creditRows; k++) begin
					label = $sformatf("credit %0d (%h)", k, creditInstr[k]);
					checkCommit(creditInstr[k], creditTaken[k], label);
				end
			end
		join
		cycles = 0;
		while (creditsLeft() != cpuCorePkg::bufferDepth && cycles < waitLimit) begin
			@(negedge CLK);
			cycles++;
		end
		testCount++;
		if (creditsLeft() != cpuCorePkg::bufferDepth) begin
			$display("Fail %0t: %0d credits left, expected %0d", $time, creditsLeft(),
				cpuCorePkg::bufferDepth);
			errorCount++;
			$display("credit count failed");
		end else begin
			$display("credit count passed");
		end

		$display("%0d tests, %0d failed", testCount, errorCount);
		if (errorCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: jumpCore.sv
`timescale 1ns/1ps
`default_nettype none

module jumpCore (
	input wire CLK,
	input wire reset,
	input wire instrPush,
	input wire [cpuCorePkg::wordWidth-1:0] instrData,
	output logic creditReturn,
	input wire regWrite,
	input wire [cpuCorePkg::regAddrWidth-1:0] regWriteAddr,
	input wire [cpuCorePkg::wordWidth-1:0] regWriteData,
	input wire ccZero,
	input wire ccCarry,
	input wire ccSign,
	input wire ccParity,
	output logic [cpuCorePkg::wordWidth-1:0] pcAddr,
	output logic commit,
	output logic jumpTaken
);

	logic bufferReady;
	logic [cpuCorePkg::wordWidth-1:0] headInstr;
	logic fetch, decode, execute, pop;
	logic isJump, isRelative, useImm;
	logic [cpuIsaPkg::condWidth-1:0] condMode;
	logic [cpuIsaPkg::flagWidth-1:0] flagSelect;
	logic [cpuCorePkg::regAddrWidth-1:0] regBAddr;
	logic [cpuIsaPkg::immWidth-1:0] imm8;
	logic [cpuCorePkg::wordWidth-1:0] operandB;

	instructionBuffer buffer (.CLK(CLK), .reset(reset), .push(instrPush),
		.pushData(instrData), .pop(pop), .ready(bufferReady),
		.headData(headInstr), .creditReturn(creditReturn));

	instructionPhaseSequencer sequencer (.CLK(CLK), .reset(reset),
		.bufferReady(bufferReady), .fetch(fetch), .decode(decode),
		.execute(execute), .commit(commit), .pop(pop));

	jumpGroupDecoder decoder (.CLK(CLK), .reset(reset), .pop(pop && fetch),
		.decode(decode), .headInstr(headInstr), .isJump(isJump),
		.isRelative(isRelative), .useImm(useImm), .condMode(condMode),
		.flagSelect(flagSelect), .regBAddr(regBAddr), .imm8(imm8));

	jumpOperandSelect operandSelect (.CLK(CLK), .reset(reset),
		.regWrite(regWrite), .regWriteAddr(regWriteAddr),
		.regWriteData(regWriteData), .execute(execute), .regBAddr(regBAddr),
		.useImm(useImm), .imm8(imm8), .operandB(operandB));

	programCounter counter (.CLK(CLK), .reset(reset), .pop(pop),
		.execute(execute), .commit(commit), .isJump(isJump),
		.isRelative(isRelative), .condMode(condMode), .flagSelect(flagSelect),
		.ccZero(ccZero), .ccCarry(ccCarry), .ccSign(ccSign),
		.ccParity(ccParity), .operandB(operandB), .pcAddr(pcAddr),
		.jumpTaken(jumpTaken));

endmodule

`default_nettype wire

// File: programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
	input wire CLK,
	input wire reset,
	input wire pop,
	input wire execute,
	input wire commit,
	input wire isJump,
	input wire isRelative,
	input wire [cpuIsaPkg::condWidth-1:0] condMode,
	input wire [cpuIsaPkg::flagWidth-1:0] flagSelect,
	input wire ccZero,
	input wire ccCarry,
	input wire ccSign,
	input wire ccParity,
	input wire [cpuCorePkg::wordWidth-1:0] operandB,
	output logic [cpuCorePkg::wordWidth-1:0] pcAddr,
	output logic jumpTaken
);

	logic selectedFlag;
	logic takeNow;
	logic takenReg;
	logic [cpuCorePkg::wordWidth-1:0] jumpTarget;

	always_comb begin
		case (flagSelect)
			cpuIsaPkg::flagZero: selectedFlag = ccZero;
			cpuIsaPkg::flagCarry: selectedFlag = ccCarry;
			cpuIsaPkg::flagSign: selectedFlag = ccSign;
			default: selectedFlag = ccParity;
		endcase
	end

	always_comb begin
		case (condMode)
			cpuIsaPkg::condAlways: takeNow = isJump;
			cpuIsaPkg::condIfSet: takeNow = isJump && selectedFlag;
			cpuIsaPkg::condIfClear: takeNow = isJump && !selectedFlag;
			default: takeNow = 1'b0; // condNever
		endcase
	end

	assign jumpTarget = isRelative ? (pcAddr + operandB) : operandB; // pc already stepped

	always_ff @(posedge CLK) begin
		if (reset) begin
			pcAddr <= '0;
			takenReg <= 1'b0;
		end else begin
			if (execute) takenReg <= takeNow;
			if (pop) begin
				pcAddr <= pcAddr + cpuCorePkg::pcStep;
			end else if (commit && takenReg) begin
				pcAddr <= jumpTarget;
			end
		end
	end

	assign jumpTaken = commit && takenReg;

endmodule

`default_nettype wire

// File: jumpOperandSelect.sv
`timescale 1ns/1ps
`default_nettype none

module jumpOperandSelect (
	input wire CLK,
	input wire reset,
	input wire regWrite,
	input wire [cpuCorePkg::regAddrWidth-1:0] regWriteAddr,
	input wire [cpuCorePkg::wordWidth-1:0] regWriteData,
	input wire execute,
	input wire [cpuCorePkg::regAddrWidth-1:0] regBAddr,
	input wire useImm,
	input wire [cpuIsaPkg::immWidth-1:0] imm8,
	output logic [cpuCorePkg::wordWidth-1:0] operandB
);

	logic [cpuCorePkg::wordWidth-1:0] regFile [cpuCorePkg::regCount];
	logic [cpuCorePkg::wordWidth-1:0] regBValue;

	// ############################################################
	// register file, loaded from outside
	// ############################################################
	always_ff @(posedge CLK) begin
		if (reset) begin
			for (int i = 0; i < cpuCorePkg::regCount; i++) begin
				regFile[i] <= '0;
			end
		end else if (regWrite) begin
			regFile[regWriteAddr] <= regWriteData;
		end
	end

	assign regBValue = regFile[regBAddr];

	// immediate forms put imm8 over the low byte of RB
	always_ff @(posedge CLK) begin
		if (execute) begin
			if (useImm) begin
				operandB <= {imm8, regBValue[cpuIsaPkg::immWidth-1:0]};
			end else begin
				operandB <= regBValue;
			end
		end
	end

endmodule

`default_nettype wire

// File: jumpGroupDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module jumpGroupDecoder (
	input wire CLK,
	input wire reset,
	input wire pop,
	input wire decode,
	input wire [cpuCorePkg::wordWidth-1:0] headInstr,
	output logic isJump,
	output logic isRelative,
	output logic useImm,
	output logic [cpuIsaPkg::condWidth-1:0] condMode,
	output logic [cpuIsaPkg::flagWidth-1:0] flagSelect,
	output logic [cpuCorePkg::regAddrWidth-1:0] regBAddr,
	output logic [cpuIsaPkg::immWidth-1:0] imm8
);

	logic [cpuCorePkg::wordWidth-1:0] instrLatch;
	logic [cpuIsaPkg::groupWidth-1:0] groupBits;
	logic [cpuIsaPkg::modeWidth-1:0] modeBits;
	logic modeIsImm;

	always_ff @(posedge CLK) begin
		if (pop) instrLatch <= headInstr; // head of buffer leaves on pop
	end

	assign groupBits = instrLatch[cpuIsaPkg::groupLsb +: cpuIsaPkg::groupWidth];
	assign modeBits = instrLatch[cpuIsaPkg::modeLsb +: cpuIsaPkg::modeWidth];
	assign modeIsImm = (modeBits == cpuIsaPkg::modeRelImm) ||
		(modeBits == cpuIsaPkg::modeAbsImm);

	// ############################################################
	// decode phase controls
	// ############################################################
	always_ff @(posedge CLK) begin
		if (reset) begin
			isJump <= 1'b0;
			isRelative <= 1'b0;
			useImm <= 1'b0;
			condMode <= cpuIsaPkg::condNever;
			flagSelect <= cpuIsaPkg::flagZero;
		end else if (decode) begin
			isJump <= (groupBits == cpuIsaPkg::groupJump); // other groups are nops
			isRelative <= (modeBits == cpuIsaPkg::modeRelReg) ||
				(modeBits == cpuIsaPkg::modeRelImm);
			useImm <= modeIsImm;
			condMode <= instrLatch[cpuIsaPkg::condLsb +: cpuIsaPkg::condWidth];
			flagSelect <= instrLatch[cpuIsaPkg::flagLsb +: cpuIsaPkg::flagWidth];
		end
	end

	always_ff @(posedge CLK) begin
		if (decode) begin
			regBAddr <= modeIsImm ? cpuIsaPkg::regRB
				: instrLatch[cpuIsaPkg::argBLsb +: cpuIsaPkg::argWidth];
			imm8 <= instrLatch[cpuIsaPkg::immLsb +: cpuIsaPkg::immWidth];
		end
	end

endmodule

`default_nettype wire

// File: instructionPhaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module instructionPhaseSequencer (
	input wire CLK,
	input wire reset,
	input wire bufferReady,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic pop
);

	logic [3:0] phaseState;
	logic [3:0] phaseNext;

	// fetch waits for a buffered word, the other phases take one cycle
	always_comb begin
		case (phaseState)
			cpuCorePkg::phaseFetch:
				phaseNext = bufferReady ? cpuCorePkg::phaseDecode : cpuCorePkg::phaseFetch;
			cpuCorePkg::phaseDecode: phaseNext = cpuCorePkg::phaseExecute;
			cpuCorePkg::phaseExecute: phaseNext = cpuCorePkg::phaseCommit;
			cpuCorePkg::phaseCommit: phaseNext = cpuCorePkg::phaseFetch;
			default: phaseNext = cpuCorePkg::phaseFetch; // recover from bad state
		endcase
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			phaseState <= cpuCorePkg::phaseFetch;
		end else begin
			phaseState <= phaseNext;
		end
	end

	assign fetch = (phaseState == cpuCorePkg::phaseFetch);
	assign decode = (phaseState == cpuCorePkg::phaseDecode);
	assign execute = (phaseState == cpuCorePkg::phaseExecute);
	assign commit = (phaseState == cpuCorePkg::phaseCommit);
	assign pop = fetch && bufferReady; // last cycle of fetch

	phaseOneHot: assert property (@(posedge CLK) disable iff (reset)
		$onehot(phaseState));

endmodule

`default_nettype wire

// File: instructionBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module instructionBuffer (
	input wire CLK,
	input wire reset,
	input wire push,
	input wire [cpuCorePkg::wordWidth-1:0] pushData,
	input wire pop,
	output logic ready,
	output logic [cpuCorePkg::wordWidth-1:0] headData,
	output logic creditReturn
);

	logic [cpuCorePkg::wordWidth-1:0] entries [cpuCorePkg::bufferDepth];
	logic [cpuCorePkg::bufferPtrWidth-1:0] wrPtr;
	logic [cpuCorePkg::bufferPtrWidth-1:0] rdPtr;
	logic [cpuCorePkg::bufferCountWidth-1:0] count;

	always_ff @(posedge CLK) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (push) wrPtr <= wrPtr + 1'b1; // wraps at depth
			if (pop) rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			creditReturn <= pop; // one credit back per popped word
		end
	end

	always_ff @(posedge CLK) begin
		if (push) entries[wrPtr] <= pushData;
	end

	assign ready = (count != '0);
	assign headData = entries[rdPtr];

	// supplier must respect its credits
	noOverflow: assert property (@(posedge CLK) disable iff (reset)
		push |-> (count < cpuCorePkg::bufferDepth));
	noUnderflow: assert property (@(posedge CLK) disable iff (reset)
		pop |-> (count != '0));

endmodule

`default_nettype wire

// File: cpuCorePkg.sv
`default_nettype none

package cpuCorePkg;

	localparam int wordWidth = 16; // instructions, data and addresses
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;

	// instruction buffer, depth doubles as the supplier's credit count
	localparam int bufferDepth = 2;
	localparam int bufferPtrWidth = 1;
	localparam int bufferCountWidth = 2;

	localparam logic [wordWidth-1:0] pcStep = 16'd2;

	// one-hot phase codes
	localparam logic [3:0] phaseFetch = 4'b0001;
	localparam logic [3:0] phaseDecode = 4'b0010;
	localparam logic [3:0] phaseExecute = 4'b0100;
	localparam logic [3:0] phaseCommit = 4'b1000;

endpackage

`default_nettype wire

// File: cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// ############################################################
	// instruction field layout
	// ############################################################
	localparam int groupLsb = 14;
	localparam int groupWidth = 2;
	localparam int condLsb = 12;
	localparam int condWidth = 2;
	localparam int modeLsb = 10;
	localparam int modeWidth = 2;
	localparam int flagLsb = 8;
	localparam int flagWidth = 2;
	localparam int argALsb = 4;
	localparam int argBLsb = 0;
	localparam int argWidth = 4;
	localparam int immLsb = 0;
	localparam int immWidth = 8;

	// ############################################################
	// encodings
	// ############################################################
	localparam logic [groupWidth-1:0] groupJump = 2'b10;

	localparam logic [condWidth-1:0] condAlways = 2'b00;
	localparam logic [condWidth-1:0] condIfSet = 2'b01;
	localparam logic [condWidth-1:0] condIfClear = 2'b10;
	localparam logic [condWidth-1:0] condNever = 2'b11;

	localparam logic [modeWidth-1:0] modeRelReg = 2'b00;
	localparam logic [modeWidth-1:0] modeRelImm = 2'b01; // imm8 over low byte of RB
	localparam logic [modeWidth-1:0] modeAbsReg = 2'b10;
	localparam logic [modeWidth-1:0] modeAbsImm = 2'b11;

	localparam logic [flagWidth-1:0] flagZero = 2'b00;
	localparam logic [flagWidth-1:0] flagCarry = 2'b01;
	localparam logic [flagWidth-1:0] flagSign = 2'b10;
	localparam logic [flagWidth-1:0] flagParity = 2'b11;

	localparam logic [argWidth-1:0] regRB = 4'd11; // base register of immediate forms
	localparam logic [15:0] instrNop = 16'h0000;

endpackage

`default_nettype wire
